// File: verilog/isaPkg.sv
package isaPkg;

    // Major opcodes
    localparam logic [6:0] OpRType  = 7'b0110011;
    localparam logic [6:0] OpIType  = 7'b0010011;
    localparam logic [6:0] OpLui    = 7'b0110111;
    localparam logic [6:0] OpJal    = 7'b1101111;
    localparam logic [6:0] OpBranch = 7'b1100011;

    // ALU funct3, shared by R-type and I-type
    localparam logic [2:0] F3Add  = 3'b000;
    localparam logic [2:0] F3Sll  = 3'b001;
    localparam logic [2:0] F3Slt  = 3'b010;
    localparam logic [2:0] F3Sltu = 3'b011;
    localparam logic [2:0] F3Xor  = 3'b100;
    localparam logic [2:0] F3Srl  = 3'b101;
    localparam logic [2:0] F3Or   = 3'b110;
    localparam logic [2:0] F3And  = 3'b111;

    // Branch funct3
    localparam logic [2:0] F3Beq  = 3'b000;
    localparam logic [2:0] F3Bne  = 3'b001;
    localparam logic [2:0] F3Blt  = 3'b100;
    localparam logic [2:0] F3Bge  = 3'b101;
    localparam logic [2:0] F3Bltu = 3'b110;
    localparam logic [2:0] F3Bgeu = 3'b111;

    // Alt selects SUB and SRA
    localparam logic [6:0] F7Base = 7'h00;
    localparam logic [6:0] F7Alt  = 7'h20;

endpackage

// File: verilog/corePkg.sv
package corePkg;

    localparam int XLen = 32;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluXor,
        AluOr,
        AluAnd,
        AluSll,
        AluSrl,
        AluSra,
        AluSlt,
        AluSltu,
        AluPassB
    } aluOpT;

    // Which instruction bits form the immediate
    typedef enum logic [2:0] {
        ImmI,
        ImmShamt,
        ImmU,
        ImmB,
        ImmJ,
        ImmNone
    } immKindT;

    typedef enum logic [2:0] {
        BrNone,
        BrEq,
        BrNe,
        BrLt,
        BrGe,
        BrLtu,
        BrGeu,
        BrJal
    } branchKindT;

endpackage

// File: verilog/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  logic [31:0]         instr,
    output corePkg::aluOpT      aluOp,
    output logic                aluSrc,
    output corePkg::immKindT    immKind,
    output logic                regWrite,
    output corePkg::branchKindT branchKind,
    output logic                illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        aluOp      = corePkg::AluAdd;
        aluSrc     = 1'b0;
        immKind    = corePkg::ImmNone;
        regWrite   = 1'b0;
        branchKind = corePkg::BrNone;
        illegal    = 1'b0;

        case (opcode)
            isaPkg::OpRType: begin
                regWrite = 1'b1;
                case (funct3)
                    isaPkg::F3Add: begin
                        case (funct7)
                            isaPkg::F7Base: aluOp = corePkg::AluAdd;
                            isaPkg::F7Alt:  aluOp = corePkg::AluSub;
                            default:        illegal = 1'b1;
                        endcase
                    end
                    isaPkg::F3Srl: begin
                        case (funct7)
                            isaPkg::F7Base: aluOp = corePkg::AluSrl;
                            isaPkg::F7Alt:  aluOp = corePkg::AluSra;
                            default:        illegal = 1'b1;
                        endcase
                    end
                    default: begin
                        // Everything else only exists with the base funct7
                        illegal = (funct7 != isaPkg::F7Base);
                        case (funct3)
                            isaPkg::F3Sll:  aluOp = corePkg::AluSll;
                            isaPkg::F3Slt:  aluOp = corePkg::AluSlt;
                            isaPkg::F3Sltu: aluOp = corePkg::AluSltu;
                            isaPkg::F3Xor:  aluOp = corePkg::AluXor;
                            isaPkg::F3Or:   aluOp = corePkg::AluOr;
                            default:        aluOp = corePkg::AluAnd;
                        endcase
                    end
                endcase
            end

            isaPkg::OpIType: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                immKind  = corePkg::ImmI;
                case (funct3)
                    isaPkg::F3Add:  aluOp = corePkg::AluAdd;
                    isaPkg::F3Slt:  aluOp = corePkg::AluSlt;
                    isaPkg::F3Sltu: aluOp = corePkg::AluSltu;
                    isaPkg::F3Xor:  aluOp = corePkg::AluXor;
                    isaPkg::F3Or:   aluOp = corePkg::AluOr;
                    isaPkg::F3And:  aluOp = corePkg::AluAnd;
                    isaPkg::F3Sll: begin
                        aluOp   = corePkg::AluSll;
                        immKind = corePkg::ImmShamt;
                        illegal = (funct7 != isaPkg::F7Base);
                    end
                    default: begin
                        immKind = corePkg::ImmShamt;
                        case (funct7)
                            isaPkg::F7Base: aluOp = corePkg::AluSrl;
                            isaPkg::F7Alt:  aluOp = corePkg::AluSra;
                            default:        illegal = 1'b1;
                        endcase
                    end
                endcase
            end

            isaPkg::OpLui: begin
                aluOp    = corePkg::AluPassB;
                aluSrc   = 1'b1;
                immKind  = corePkg::ImmU;
                regWrite = 1'b1;
            end

            // Link value is formed in execute
            isaPkg::OpJal: begin
                regWrite   = 1'b1;
                immKind    = corePkg::ImmJ;
                branchKind = corePkg::BrJal;
            end

            isaPkg::OpBranch: begin
                immKind = corePkg::ImmB;
                case (funct3)
                    isaPkg::F3Beq:  branchKind = corePkg::BrEq;
                    isaPkg::F3Bne:  branchKind = corePkg::BrNe;
                    isaPkg::F3Blt:  branchKind = corePkg::BrLt;
                    isaPkg::F3Bge:  branchKind = corePkg::BrGe;
                    isaPkg::F3Bltu: branchKind = corePkg::BrLtu;
                    isaPkg::F3Bgeu: branchKind = corePkg::BrGeu;
                    default:        illegal = 1'b1;
                endcase
            end

            default: illegal = 1'b1;
        endcase

        // Illegal retires as a plain no-op
        if (illegal) begin
            regWrite   = 1'b0;
            branchKind = corePkg::BrNone;
        end
    end

endmodule

// File: verilog/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       instrStrobe,
    input  logic [31:0]                instr,
    output logic                       decodedStrobe,
    output corePkg::aluOpT             aluOp,
    output logic                       aluSrc,
    output logic [corePkg::XLen-1:0]   imm,
    output logic [4:0]                 rs1,
    output logic [4:0]                 rs2,
    output logic [4:0]                 rd,
    output logic                       regWrite,
    output corePkg::branchKindT        branchKind,
    output logic                       illegal
);

    corePkg::aluOpT             cuAluOp;
    logic                       cuAluSrc;
    corePkg::immKindT           cuImmKind;
    logic                       cuRegWrite;
    corePkg::branchKindT        cuBranchKind;
    logic                       cuIllegal;
    logic [corePkg::XLen-1:0]   immValue;

    controlUnit i_controlUnit (
        .instr      (instr),
        .aluOp      (cuAluOp),
        .aluSrc     (cuAluSrc),
        .immKind    (cuImmKind),
        .regWrite   (cuRegWrite),
        .branchKind (cuBranchKind),
        .illegal    (cuIllegal)
    );

    // Sign-extended immediate
    always_comb begin
        case (cuImmKind)
            corePkg::ImmI:     immValue = {{(corePkg::XLen-12){instr[31]}}, instr[31:20]};
            corePkg::ImmShamt: immValue = {{(corePkg::XLen-5){1'b0}}, instr[24:20]};
            corePkg::ImmU:     immValue = {instr[31:12], 12'b0};
            corePkg::ImmB:     immValue = {{(corePkg::XLen-12){instr[31]}}, instr[7],
                                           instr[30:25], instr[11:8], 1'b0};
            corePkg::ImmJ:     immValue = {{(corePkg::XLen-20){instr[31]}}, instr[19:12],
                                           instr[20], instr[30:21], 1'b0};
            default:           immValue = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decodedStrobe <= 1'b0;
        end else begin
            decodedStrobe <= instrStrobe;
        end
    end

    // Decoded fields, qualified by decodedStrobe
    always_ff @(posedge clk) begin
        if (instrStrobe) begin
            aluOp      <= cuAluOp;
            aluSrc     <= cuAluSrc;
            imm        <= immValue;
            rs1        <= instr[19:15];
            rs2        <= instr[24:20];
            rd         <= instr[11:7];
            regWrite   <= cuRegWrite;
            branchKind <= cuBranchKind;
            illegal    <= cuIllegal;
        end
    end

endmodule

// File: verilog/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [4:0]                 rs1,
    input  logic [4:0]                 rs2,
    input  logic                       wrEnable,
    input  logic [4:0]                 wrAddr,
    input  logic [corePkg::XLen-1:0]   wrData,
    output logic [corePkg::XLen-1:0]   rs1Data,
    output logic [corePkg::XLen-1:0]   rs2Data
);

    // x0 has no storage
    logic [corePkg::XLen-1:0] regs [31:1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEnable && (wrAddr != 5'd0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Write-through, the retiring result is visible in the same cycle
    always_comb begin
        if (rs1 == 5'd0) begin
            rs1Data = '0;
        end else if (wrEnable && (wrAddr == rs1)) begin
            rs1Data = wrData;
        end else begin
            rs1Data = regs[rs1];
        end
        if (rs2 == 5'd0) begin
            rs2Data = '0;
        end else if (wrEnable && (wrAddr == rs2)) begin
            rs2Data = wrData;
        end else begin
            rs2Data = regs[rs2];
        end
    end

endmodule

// File: verilog/executeUnit.sv
`timescale 1ns/1ps

module executeUnit (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       decodedStrobe,
    input  corePkg::aluOpT             aluOp,
    input  logic                       aluSrc,
    input  logic [corePkg::XLen-1:0]   imm,
    input  logic [4:0]                 rs1,
    input  logic [4:0]                 rs2,
    input  logic [4:0]                 rd,
    input  logic                       regWrite,
    input  corePkg::branchKindT        branchKind,
    input  logic                       illegal,
    input  logic [corePkg::XLen-1:0]   rs1Data,
    input  logic [corePkg::XLen-1:0]   rs2Data,
    output logic [4:0]                 rs1Addr,
    output logic [4:0]                 rs2Addr,
    output logic                       retireStrobe,
    output logic [corePkg::XLen-1:0]   retirePc,
    output logic [corePkg::XLen-1:0]   nextPc,
    output logic                       wrEnable,
    output logic [4:0]                 wrAddr,
    output logic [corePkg::XLen-1:0]   wrData,
    output logic                       branchTaken,
    output logic                       retireIllegal
);

    logic [corePkg::XLen-1:0] pc;
    logic [corePkg::XLen-1:0] pcPlus4;
    logic [corePkg::XLen-1:0] target;
    logic [corePkg::XLen-1:0] operandB;
    logic [corePkg::XLen-1:0] aluResult;
    logic [corePkg::XLen-1:0] nextPcValue;
    logic                     taken;

    assign rs1Addr  = rs1;
    assign rs2Addr  = rs2;
    assign operandB = aluSrc ? imm : rs2Data;
    assign pcPlus4  = pc + 'd4;
    assign target   = pc + imm;

    always_comb begin
        case (aluOp)
            corePkg::AluAdd:  aluResult = rs1Data + operandB;
            corePkg::AluSub:  aluResult = rs1Data - operandB;
            corePkg::AluXor:  aluResult = rs1Data ^ operandB;
            corePkg::AluOr:   aluResult = rs1Data | operandB;
            corePkg::AluAnd:  aluResult = rs1Data & operandB;
            corePkg::AluSll:  aluResult = rs1Data << operandB[4:0];
            corePkg::AluSrl:  aluResult = rs1Data >> operandB[4:0];
            corePkg::AluSra:  aluResult = $unsigned($signed(rs1Data) >>> operandB[4:0]);
            corePkg::AluSlt:  aluResult = {{(corePkg::XLen-1){1'b0}},
                                           $signed(rs1Data) < $signed(operandB)};
            corePkg::AluSltu: aluResult = {{(corePkg::XLen-1){1'b0}}, rs1Data < operandB};
            default:          aluResult = operandB;
        endcase
    end

    // Branch resolution
    always_comb begin
        case (branchKind)
            corePkg::BrEq:  taken = (rs1Data == rs2Data);
            corePkg::BrNe:  taken = (rs1Data != rs2Data);
            corePkg::BrLt:  taken = ($signed(rs1Data) < $signed(rs2Data));
            corePkg::BrGe:  taken = ($signed(rs1Data) >= $signed(rs2Data));
            corePkg::BrLtu: taken = (rs1Data < rs2Data);
            corePkg::BrGeu: taken = (rs1Data >= rs2Data);
            corePkg::BrJal: taken = 1'b1;
            default:        taken = 1'b0;
        endcase
        nextPcValue = taken ? target : pcPlus4;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc            <= '0;
            retireStrobe  <= 1'b0;
            wrEnable      <= 1'b0;
            retirePc      <= '0;
            nextPc        <= '0;
            branchTaken   <= 1'b0;
            retireIllegal <= 1'b0;
        end else begin
            retireStrobe <= decodedStrobe;
            // x0 writes never leave the core
            wrEnable     <= decodedStrobe && regWrite && (rd != 5'd0);
            if (decodedStrobe) begin
                pc            <= nextPcValue;
                retirePc      <= pc;
                nextPc        <= nextPcValue;
                branchTaken   <= taken;
                retireIllegal <= illegal;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (decodedStrobe) begin
            wrAddr <= rd;
            wrData <= (branchKind == corePkg::BrJal) ? pcPlus4 : aluResult;
        end
    end

endmodule

// File: verilog/coreTop.sv
`timescale 1ns/1ps

module coreTop (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       instrStrobe,
    input  logic [31:0]                instr,
    output logic                       retireStrobe,
    output logic [corePkg::XLen-1:0]   retirePc,
    output logic [corePkg::XLen-1:0]   nextPc,
    output logic                       wrEnable,
    output logic [4:0]                 wrAddr,
    output logic [corePkg::XLen-1:0]   wrData,
    output logic                       branchTaken,
    output logic                       illegal
);

    // Decode to execute
    logic                       decodedStrobe;
    corePkg::aluOpT             decAluOp;
    logic                       decAluSrc;
    logic [corePkg::XLen-1:0]   decImm;
    logic [4:0]                 decRs1;
    logic [4:0]                 decRs2;
    logic [4:0]                 decRd;
    logic                       decRegWrite;
    corePkg::branchKindT        decBranchKind;
    logic                       decIllegal;

    // Register file read ports
    logic [4:0]                 rfRs1;
    logic [4:0]                 rfRs2;
    logic [corePkg::XLen-1:0]   rs1Data;
    logic [corePkg::XLen-1:0]   rs2Data;

    instrDecoder i_instrDecoder (
        .clk           (clk),
        .reset         (reset),
        .instrStrobe   (instrStrobe),
        .instr         (instr),
        .decodedStrobe (decodedStrobe),
        .aluOp         (decAluOp),
        .aluSrc        (decAluSrc),
        .imm           (decImm),
        .rs1           (decRs1),
        .rs2           (decRs2),
        .rd            (decRd),
        .regWrite      (decRegWrite),
        .branchKind    (decBranchKind),
        .illegal       (decIllegal)
    );

    registerFile i_registerFile (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rfRs1),
        .rs2      (rfRs2),
        .wrEnable (wrEnable),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .rs1Data  (rs1Data),
        .rs2Data  (rs2Data)
    );

    executeUnit i_executeUnit (
        .clk           (clk),
        .reset         (reset),
        .decodedStrobe (decodedStrobe),
        .aluOp         (decAluOp),
        .aluSrc        (decAluSrc),
        .imm           (decImm),
        .rs1           (decRs1),
        .rs2           (decRs2),
        .rd            (decRd),
        .regWrite      (decRegWrite),
        .branchKind    (decBranchKind),
        .illegal       (decIllegal),
        .rs1Data       (rs1Data),
        .rs2Data       (rs2Data),
        .rs1Addr       (rfRs1),
        .rs2Addr       (rfRs2),
        .retireStrobe  (retireStrobe),
        .retirePc      (retirePc),
        .nextPc        (nextPc),
        .wrEnable      (wrEnable),
        .wrAddr        (wrAddr),
        .wrData        (wrData),
        .branchTaken   (branchTaken),
        .retireIllegal (illegal)
    );

endmodule

// File: testbench/core_checker.sv
`timescale 1ns/1ps

module core_checker (
    input logic                     clk,
    input logic                     reset,
    input logic                     decodedStrobe,
    input logic                     retireStrobe,
    input logic                     wrEnable,
    input logic [4:0]               wrAddr,
    input logic [corePkg::XLen-1:0] nextPc
);

    // Execute takes exactly one cycle
    assert property (@(posedge clk) disable iff (reset) retireStrobe == $past(decodedStrobe))
        else $error("retireStrobe does not follow decodedStrobe by one cycle");

    assert property (@(posedge clk) disable iff (reset) !(wrEnable && wrAddr == 5'd0))
        else $error("register write to x0");

    assert property (@(posedge clk) disable iff (reset) nextPc[1:0] == 2'b00)
        else $error("nextPc not word aligned");

endmodule

bind executeUnit core_checker i_coreChecker (
    .clk           (clk),
    .reset         (reset),
    .decodedStrobe (decodedStrobe),
    .retireStrobe  (retireStrobe),
    .wrEnable      (wrEnable),
    .wrAddr        (wrAddr),
    .nextPc        (nextPc)
);

// File: testbench/tb_core.sv
`timescale 1ns/1ps

module tb_core;

    localparam int NumInstr = 400;
    localparam logic [6:0] IllegalOps [4] = '{7'b0000011, 7'b0100011, 7'b0010111, 7'b1100111};

    typedef struct packed {
        logic [corePkg::XLen-1:0] pc;
        logic [corePkg::XLen-1:0] nextPc;
        logic                     wrEnable;
        logic [4:0]               wrAddr;
        logic [corePkg::XLen-1:0] wrData;
        logic                     taken;
        logic                     illegal;
        int                       sendCycle;
    } retireT;

    logic                     clk;
    logic                     reset;
    logic                     instrStrobe;
    logic [31:0]              instr;
    logic                     retireStrobe;
    logic [corePkg::XLen-1:0] retirePc;
    logic [corePkg::XLen-1:0] nextPc;
    logic                     wrEnable;
    logic [4:0]               wrAddr;
    logic [corePkg::XLen-1:0] wrData;
    logic                     branchTaken;
    logic                     illegal;

    logic [corePkg::XLen-1:0] modelRegs [32];
    logic [corePkg::XLen-1:0] modelPc;
    retireT                   expQ [$];
    int                       cycle = 0;
    int                       retired = 0;

    coreTop i_coreTop (
        .clk          (clk),
        .reset        (reset),
        .instrStrobe  (instrStrobe),
        .instr        (instr),
        .retireStrobe (retireStrobe),
        .retirePc     (retirePc),
        .nextPc       (nextPc),
        .wrEnable     (wrEnable),
        .wrAddr       (wrAddr),
        .wrData       (wrData),
        .branchTaken  (branchTaken),
        .illegal      (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic reportFailure(string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic compareHex(string name, logic [31:0] got, logic [31:0] expected);
        assert (got === expected) else begin
            reportFailure($sformatf("error %s: got 0x%08h, expected 0x%08h", name, got, expected));
        end
    endtask

    function automatic logic [31:0] aluModel(logic [2:0] f3, logic alt, logic [31:0] a,
                                             logic [31:0] b);
        case (f3)
            isaPkg::F3Add:  return alt ? a - b : a + b;
            isaPkg::F3Sll:  return a << b[4:0];
            isaPkg::F3Slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            isaPkg::F3Sltu: return (a < b) ? 32'd1 : 32'd0;
            isaPkg::F3Xor:  return a ^ b;
            isaPkg::F3Srl:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            isaPkg::F3Or:   return a | b;
            default:        return a & b;
        endcase
    endfunction

    function automatic logic branchModel(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            isaPkg::F3Beq:  return a == b;
            isaPkg::F3Bne:  return a != b;
            isaPkg::F3Blt:  return $signed(a) < $signed(b);
            isaPkg::F3Bge:  return $signed(a) >= $signed(b);
            isaPkg::F3Bltu: return a < b;
            default:        return a >= b;
        endcase
    endfunction

    // Small register range so that results get reused
    function automatic logic [31:0] randomInstr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [2:0]  f3b;
        logic [6:0]  f7;
        logic [20:0] off;
        rd  = 5'($urandom_range(0, 7));
        rs1 = 5'($urandom_range(0, 7));
        rs2 = 5'($urandom_range(0, 7));
        f3  = 3'($urandom_range(0, 7));
        f3b = 3'($urandom_range(0, 5));
        f3b = (f3b < 3'd2) ? f3b : f3b + 3'd2;
        f7  = isaPkg::F7Base;
        if ((f3 == isaPkg::F3Add || f3 == isaPkg::F3Srl) && $urandom_range(0, 1) == 1) begin
            f7 = isaPkg::F7Alt;
        end
        off = 21'(($urandom_range(0, 1023) - 512) * 4);
        case ($urandom_range(0, 9))
            0, 1, 2: return {f7, rs2, rs1, f3, rd, isaPkg::OpRType};
            3, 4: begin
                if (f3 == isaPkg::F3Sll || f3 == isaPkg::F3Srl) begin
                    return {f7, 5'($urandom), rs1, f3, rd, isaPkg::OpIType};
                end
                return {12'($urandom), rs1, f3, rd, isaPkg::OpIType};
            end
            5: return {20'($urandom), rd, isaPkg::OpLui};
            6: return {off[20], off[10:1], off[11], off[19:12], rd, isaPkg::OpJal};
            7, 8: return {off[12], off[10:5], rs2, rs1, f3b, off[4:1], off[11],
                          isaPkg::OpBranch};
            default: return {25'($urandom), IllegalOps[$urandom_range(0, 3)]};
        endcase
    endfunction

    // Reference model, advances its own registers and counter
    function automatic retireT modelStep(logic [31:0] ins);
        retireT      r;
        logic [6:0]  op;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        wr;
        op = ins[6:0];
        f3 = ins[14:12];
        a = modelRegs[ins[19:15]];
        b = modelRegs[ins[24:20]];
        r = '0;
        r.pc = modelPc;
        r.nextPc = modelPc + 32'd4;
        r.wrAddr = ins[11:7];
        wr = 1'b1;
        res = '0;
        case (op)
            isaPkg::OpRType: res = aluModel(f3, ins[30], a, b);
            isaPkg::OpIType: res = aluModel(f3, ins[30] && f3 == isaPkg::F3Srl, a,
                                            {{20{ins[31]}}, ins[31:20]});
            isaPkg::OpLui:   res = {ins[31:12], 12'b0};
            isaPkg::OpJal: begin
                res = modelPc + 32'd4;
                r.taken = 1'b1;
                r.nextPc = modelPc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            isaPkg::OpBranch: begin
                wr = 1'b0;
                r.taken = branchModel(f3, a, b);
                if (r.taken) begin
                    r.nextPc = modelPc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            default: begin
                wr = 1'b0;
                r.illegal = 1'b1;
            end
        endcase
        r.wrEnable = wr && (r.wrAddr != 5'd0);
        r.wrData = res;
        if (r.wrEnable) begin
            modelRegs[r.wrAddr] = res;
        end
        modelPc = r.nextPc;
        return r;
    endfunction

    task automatic checkRetire();
        retireT e;
        if (!retireStrobe) begin
            compareHex("wrEnable", {31'b0, wrEnable}, 32'd0);
            assert (expQ.size() == 0 || cycle < expQ[0].sendCycle + 2) else begin
                reportFailure("no retire two cycles after an instruction was sent");
            end
        end else begin
            assert (expQ.size() != 0) else begin
                reportFailure("retire seen with no instruction outstanding");
            end
            e = expQ.pop_front();
            assert (cycle == e.sendCycle + 2) else begin
                reportFailure("retire did not come two cycles after its instruction");
            end
            compareHex("retirePc", retirePc, e.pc);
            compareHex("nextPc", nextPc, e.nextPc);
            compareHex("branchTaken", {31'b0, branchTaken}, {31'b0, e.taken});
            compareHex("illegal", {31'b0, illegal}, {31'b0, e.illegal});
            compareHex("wrEnable", {31'b0, wrEnable}, {31'b0, e.wrEnable});
            if (e.wrEnable) begin
                compareHex("wrAddr", {27'b0, wrAddr}, {27'b0, e.wrAddr});
                compareHex("wrData", wrData, e.wrData);
            end
            retired++;
        end
    endtask

    // Outputs only move on the rising edge
    initial begin
        forever begin
            @(negedge clk);
            if (!reset) begin
                checkRetire();
            end
        end
    end

    initial begin
        retireT r;
        void'($urandom(81416));
        reset = 1'b1;
        instrStrobe = 1'b0;
        instr = '0;
        modelPc = '0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int n = 0; n < NumInstr; n++) begin
            repeat ($urandom_range(0, 2)) @(negedge clk);
            instr = randomInstr();
            instrStrobe = 1'b1;
            r = modelStep(instr);
            r.sendCycle = cycle;
            expQ.push_back(r);
            @(negedge clk);
            instrStrobe = 1'b0;
        end
        for (int t = 0; t < 10 && expQ.size() != 0; t++) begin
            @(posedge clk);
        end
        if (expQ.size() == 0 && retired == NumInstr) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            reportFailure("timed out waiting for the last instructions to retire");
        end
    end

endmodule

// File: sim.f
verilog/isaPkg.sv
verilog/corePkg.sv
verilog/controlUnit.sv
verilog/instrDecoder.sv
verilog/registerFile.sv
verilog/executeUnit.sv
verilog/coreTop.sv
testbench/core_checker.sv
testbench/tb_core.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_core -f sim.f -o simCore || exit 1
out=$(./obj_dir/simCore 2>&1)
echo "$out"
echo "$out" | grep -qx "=== PASS ===" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
